//--- hdl/saturn_dec_cfg.svh
// width macros for nibbles, program addresses and register ids
`ifndef SATURN_DEC_CFG_SVH
`define SATURN_DEC_CFG_SVH

// one instruction nibble, also the width of a digit index and of P
`define SATURN_NIBBLE_W 4

// program counter and instruction address
`define SATURN_ADDR_W 20

// ALU register id
`define SATURN_REG_ID_W 5

`endif

//--- hdl/saturn_alu_pkg.sv
// ALU operation and register id enums for the decoder outputs
`default_nettype none

`include "saturn_dec_cfg.svh"

package saturn_alu_pkg;

  // operations the decoder can request from the ALU
  typedef enum logic [4:0] {
    ALU_OP_ZERO = 5'd0,
    ALU_OP_COPY = 5'd1,
    ALU_OP_EXCH = 5'd2,
    ALU_OP_INC  = 5'd3,
    ALU_OP_DEC  = 5'd4,
    ALU_OP_AND  = 5'd5,
    ALU_OP_OR   = 5'd6
  } alu_op_e;

  // registers addressed by the group 0 instructions
  // A doubles as the cleared value
  typedef enum logic [`SATURN_REG_ID_W-1:0] {
    ALU_REG_A    = 5'd0,
    ALU_REG_C    = 5'd1,
    ALU_REG_RSTK = 5'd2,
    ALU_REG_ST   = 5'd3
  } alu_reg_e;

endpackage

`default_nettype wire

//--- hdl/saturn_field_pkg.sv
// field codes, field bounds struct and decode step enum
`default_nettype none

`include "saturn_dec_cfg.svh"

package saturn_field_pkg;

  // field selected by the instruction, NONE for fixed bounds
  typedef enum logic [3:0] {
    FIELD_NONE = 4'd0,
    FIELD_P    = 4'd1,
    FIELD_WP   = 4'd2,
    FIELD_XS   = 4'd3,
    FIELD_X    = 4'd4,
    FIELD_S    = 4'd5,
    FIELD_M    = 4'd6,
    FIELD_B    = 4'd7,
    FIELD_W    = 4'd8,
    FIELD_A    = 4'd9
  } field_e;

  // digit range of a 16 digit register
  typedef struct packed {
    field_e                      code;
    logic [`SATURN_NIBBLE_W-1:0] start_digit;
    logic [`SATURN_NIBBLE_W-1:0] last_digit;
  } field_bounds_t;

  // which nibble of the instruction is expected next
  typedef enum logic [1:0] {
    STEP_FIRST  = 2'd0,
    STEP_GROUP0 = 2'd1,
    STEP_FIELD  = 2'd2,
    STEP_OP     = 2'd3
  } dec_step_e;

endpackage

`default_nettype wire

//--- hdl/saturn_dec_step_if.sv
// per-nibble step bundle between the sequencer and the two decoders
`default_nettype none
`timescale 1ns/10ps

`include "saturn_dec_cfg.svh"

interface saturn_dec_step_if;

  // strobes from the sequencer
  logic                        valid;
  logic                        start;
  saturn_field_pkg::dec_step_e step;
  logic [`SATURN_NIBBLE_W-1:0] nibble;

  // verdicts on the current nibble, combinational
  logic                        extend;
  logic                        bad_group0;
  logic                        bad_field;

  modport seq (
    output valid, start, step, nibble,
    input  extend, bad_group0, bad_field
  );

  modport group0 (
    input  valid, start, step, nibble,
    output extend, bad_group0
  );

  modport field (
    input  valid, start, step, nibble,
    output bad_field
  );

endinterface

`default_nettype wire

//--- hdl/saturn_nibble_sequencer.sv
// instruction step FSM, start address latch, decoded and error pulses
`default_nettype none
`timescale 1ns/10ps

`include "saturn_dec_cfg.svh"

module saturn_nibble_sequencer (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire                         i_en_dec,
  input  wire                         i_stalled,
  input  wire  [`SATURN_ADDR_W-1:0]   i_pc,
  input  wire  [`SATURN_NIBBLE_W-1:0] i_nibble,
  saturn_dec_step_if.seq              step,
  output logic [`SATURN_ADDR_W-1:0]   o_ins_addr,
  output logic                        o_ins_decoded,
  output logic                        o_dec_error
);

  saturn_field_pkg::dec_step_e step_q;
  saturn_field_pkg::dec_step_e step_d;
  logic                        accept;
  logic                        finish;
  logic                        fail;

  // a stalled cycle accepts nothing
  assign accept = i_en_dec && !i_stalled;

  assign step.valid  = accept;
  assign step.step   = step_q;
  assign step.nibble = i_nibble;
  assign step.start  = accept && (step_q == saturn_field_pkg::STEP_FIRST);

  // next step and end of instruction, from the decoders' verdicts
  always_comb begin
    step_d = step_q;
    finish = 1'b0;
    fail   = 1'b0;
    case (step_q)
      saturn_field_pkg::STEP_FIRST: begin
        // only group 0 exists
        if (i_nibble == '0) begin
          step_d = saturn_field_pkg::STEP_GROUP0;
        end else begin
          fail = 1'b1;
        end
      end
      saturn_field_pkg::STEP_GROUP0: begin
        if (step.bad_group0) begin
          fail = 1'b1;
        end else if (step.extend) begin
          step_d = saturn_field_pkg::STEP_FIELD;
        end else begin
          finish = 1'b1;
        end
      end
      saturn_field_pkg::STEP_FIELD: begin
        if (step.bad_field) begin
          fail = 1'b1;
        end else begin
          step_d = saturn_field_pkg::STEP_OP;
        end
      end
      saturn_field_pkg::STEP_OP: begin
        if (step.bad_group0) begin
          fail = 1'b1;
        end else begin
          finish = 1'b1;
        end
      end
    endcase
    // errors restart at the next nibble
    if (finish || fail) begin
      step_d = saturn_field_pkg::STEP_FIRST;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      step_q        <= saturn_field_pkg::STEP_FIRST;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else begin
      // pulses last one cycle, stalled or not
      o_ins_decoded <= accept && finish;
      o_dec_error   <= accept && fail;
      if (accept) begin
        step_q <= step_d;
      end
    end
  end

  // address of the first nibble
  always_ff @(posedge i_clk) begin
    if (step.start) begin
      o_ins_addr <= i_pc;
    end
  end

endmodule

`default_nettype wire

//--- hdl/saturn_group0_decoder.sv
// group 0 second nibble and 0Efx op nibble decode into flags, ALU op and registers
`default_nettype none
`timescale 1ns/10ps

module saturn_group0_decoder (
  input  wire                      i_clk,
  input  wire                      i_reset,
  saturn_dec_step_if.group0        step,
  output logic                     o_push,
  output logic                     o_pop,
  output logic                     o_ins_alu_op,
  output saturn_alu_pkg::alu_op_e  o_alu_op,
  output saturn_alu_pkg::alu_reg_e o_reg_dest,
  output saturn_alu_pkg::alu_reg_e o_reg_src1,
  output saturn_alu_pkg::alu_reg_e o_reg_src2,
  output logic                     o_ins_rtn,
  output logic                     o_set_xm,
  output logic                     o_set_carry,
  output logic                     o_carry_val,
  output logic                     o_ins_set_mode,
  output logic                     o_mode_dec
);

  logic in_group0;
  logic in_op;

  assign in_group0 = (step.step == saturn_field_pkg::STEP_GROUP0);
  assign in_op     = (step.step == saturn_field_pkg::STEP_OP);

  // 0E opens the logical group, 0F is not supported
  assign step.extend     = in_group0 && (step.nibble == 4'hE);
  // op nibble x only uses bit 3 (AND/OR) and bit 0 (register pair)
  assign step.bad_group0 = (in_group0 && (step.nibble == 4'hF)) ||
                           (in_op && (step.nibble[2:1] != 2'b00));

  always_ff @(posedge i_clk) begin
    if (i_reset || (step.valid && step.start)) begin
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_ins_alu_op   <= 1'b0;
      o_alu_op       <= saturn_alu_pkg::ALU_OP_ZERO;
      o_reg_dest     <= saturn_alu_pkg::ALU_REG_A;
      o_reg_src1     <= saturn_alu_pkg::ALU_REG_A;
      o_reg_src2     <= saturn_alu_pkg::ALU_REG_A;
      o_ins_rtn      <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
    end else if (step.valid && in_group0) begin
      case (step.nibble)
        4'h0, 4'h1, 4'h2, 4'h3: begin
          o_ins_rtn   <= 1'b1;
          o_set_xm    <= (step.nibble == 4'h0);
          o_set_carry <= (step.nibble[3:1] == 3'b001);
          // RTNSC sets carry, RTNCC clears it
          o_carry_val <= (step.nibble == 4'h2);
        end
        4'h4, 4'h5: begin
          o_ins_set_mode <= 1'b1;
          o_mode_dec     <= step.nibble[0];
        end
        4'h6: begin
          // RSTK=C pushes onto the return stack
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_COPY;
          o_push       <= 1'b1;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_RSTK;
          o_reg_src1   <= saturn_alu_pkg::ALU_REG_C;
        end
        4'h7: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_COPY;
          o_pop        <= 1'b1;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_C;
          o_reg_src1   <= saturn_alu_pkg::ALU_REG_RSTK;
        end
        4'h8: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_ZERO;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_ST;
        end
        4'h9: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_COPY;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_C;
          o_reg_src1   <= saturn_alu_pkg::ALU_REG_ST;
        end
        4'hA: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_COPY;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_ST;
          o_reg_src1   <= saturn_alu_pkg::ALU_REG_C;
        end
        4'hB: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= saturn_alu_pkg::ALU_OP_EXCH;
          o_reg_dest   <= saturn_alu_pkg::ALU_REG_C;
          o_reg_src1   <= saturn_alu_pkg::ALU_REG_ST;
        end
        4'hC, 4'hD: begin
          // P=P+1 and P=P-1, register ids stay cleared
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= step.nibble[0] ? saturn_alu_pkg::ALU_OP_DEC
                                         : saturn_alu_pkg::ALU_OP_INC;
        end
        default: begin
        end
      endcase
    end else if (step.valid && in_op && !step.bad_group0) begin
      o_ins_alu_op <= 1'b1;
      o_alu_op     <= step.nibble[3] ? saturn_alu_pkg::ALU_OP_OR
                                     : saturn_alu_pkg::ALU_OP_AND;
      // bit 0 picks A=A op C or C=C op A
      if (step.nibble[0]) begin
        o_reg_dest <= saturn_alu_pkg::ALU_REG_C;
        o_reg_src1 <= saturn_alu_pkg::ALU_REG_C;
        o_reg_src2 <= saturn_alu_pkg::ALU_REG_A;
      end else begin
        o_reg_dest <= saturn_alu_pkg::ALU_REG_A;
        o_reg_src1 <= saturn_alu_pkg::ALU_REG_A;
        o_reg_src2 <= saturn_alu_pkg::ALU_REG_C;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/saturn_field_decoder.sv
// field code and digit bounds from fixed group 0 ranges and field table f
`default_nettype none
`timescale 1ns/10ps

`include "saturn_dec_cfg.svh"

module saturn_field_decoder (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire  [`SATURN_NIBBLE_W-1:0] i_reg_p,
  saturn_dec_step_if.field            step,
  output saturn_field_pkg::field_e    o_field,
  output logic [`SATURN_NIBBLE_W-1:0] o_field_start,
  output logic [`SATURN_NIBBLE_W-1:0] o_field_last
);

  saturn_field_pkg::field_bounds_t bounds_q;
  saturn_field_pkg::field_bounds_t table_f;
  logic                            in_group0;
  logic                            in_field;

  assign in_group0 = (step.step == saturn_field_pkg::STEP_GROUP0);
  assign in_field  = (step.step == saturn_field_pkg::STEP_FIELD);

  // table f has no entries for 8 to E
  assign step.bad_field = in_field && step.nibble[3] && (step.nibble != 4'hF);

  // table f lookup
  always_comb begin
    case (step.nibble)
      4'h0: table_f = '{saturn_field_pkg::FIELD_P, i_reg_p, i_reg_p};
      4'h1: table_f = '{saturn_field_pkg::FIELD_WP, 4'd0, i_reg_p};
      4'h2: table_f = '{saturn_field_pkg::FIELD_XS, 4'd2, 4'd2};
      4'h3: table_f = '{saturn_field_pkg::FIELD_X, 4'd0, 4'd2};
      4'h4: table_f = '{saturn_field_pkg::FIELD_S, 4'd15, 4'd15};
      4'h5: table_f = '{saturn_field_pkg::FIELD_M, 4'd3, 4'd14};
      4'h6: table_f = '{saturn_field_pkg::FIELD_B, 4'd0, 4'd1};
      4'h7: table_f = '{saturn_field_pkg::FIELD_W, 4'd0, 4'd15};
      4'hF: table_f = '{saturn_field_pkg::FIELD_A, 4'd0, 4'd4};
      default: table_f = '{saturn_field_pkg::FIELD_NONE, 4'd0, 4'd0};
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || (step.valid && step.start)) begin
      bounds_q <= '{saturn_field_pkg::FIELD_NONE, 4'd0, 4'd0};
    end else if (step.valid && in_group0) begin
      case (step.nibble)
        // return stack moves use the 5 digit address part
        4'h6, 4'h7: bounds_q <= '{saturn_field_pkg::FIELD_NONE, 4'd0, 4'd4};
        // ST is 4 digits wide
        4'h8, 4'h9, 4'hA, 4'hB: begin
          bounds_q <= '{saturn_field_pkg::FIELD_NONE, 4'd0, 4'd3};
        end
        default: begin
        end
      endcase
    end else if (step.valid && in_field && !step.bad_field) begin
      bounds_q <= table_f;
    end
  end

  assign o_field       = bounds_q.code;
  assign o_field_start = bounds_q.start_digit;
  assign o_field_last  = bounds_q.last_digit;

endmodule

`default_nettype wire

//--- hdl/saturn_decoder.sv
// nibble-serial instruction decoder top with sequencer, group 0 and field decoders
`default_nettype none
`timescale 1ns/10ps

`include "saturn_dec_cfg.svh"

module saturn_decoder (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire                         i_en_dec,
  input  wire                         i_stalled,
  input  wire  [`SATURN_ADDR_W-1:0]   i_pc,
  input  wire  [`SATURN_NIBBLE_W-1:0] i_nibble,
  input  wire  [`SATURN_NIBBLE_W-1:0] i_reg_p,
  output logic [`SATURN_ADDR_W-1:0]   o_ins_addr,
  output logic                        o_ins_decoded,
  output logic                        o_dec_error,
  output logic                        o_push,
  output logic                        o_pop,
  output logic                        o_ins_alu_op,
  output saturn_alu_pkg::alu_op_e     o_alu_op,
  output saturn_alu_pkg::alu_reg_e    o_reg_dest,
  output saturn_alu_pkg::alu_reg_e    o_reg_src1,
  output saturn_alu_pkg::alu_reg_e    o_reg_src2,
  output logic                        o_ins_rtn,
  output logic                        o_set_xm,
  output logic                        o_set_carry,
  output logic                        o_carry_val,
  output logic                        o_ins_set_mode,
  output logic                        o_mode_dec,
  output saturn_field_pkg::field_e    o_field,
  output logic [`SATURN_NIBBLE_W-1:0] o_field_start,
  output logic [`SATURN_NIBBLE_W-1:0] o_field_last
);

  // accepted nibble and verdicts shared by all three blocks
  saturn_dec_step_if step_if ();

  saturn_nibble_sequencer seq_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_stalled     (i_stalled),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .step          (step_if.seq),
    .o_ins_addr    (o_ins_addr),
    .o_ins_decoded (o_ins_decoded),
    .o_dec_error   (o_dec_error)
  );

  saturn_group0_decoder group0_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .step           (step_if.group0),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_alu_op       (o_alu_op),
    .o_reg_dest     (o_reg_dest),
    .o_reg_src1     (o_reg_src1),
    .o_reg_src2     (o_reg_src2),
    .o_ins_rtn      (o_ins_rtn),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec)
  );

  saturn_field_decoder field_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_reg_p       (i_reg_p),
    .step          (step_if.field),
    .o_field       (o_field),
    .o_field_start (o_field_start),
    .o_field_last  (o_field_last)
  );

endmodule

`default_nettype wire

//--- testbench/saturn_decoder_tests.svh
// directed decoder tests with nibble driver, expectation setup and output checks

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("** Error: %s = %h, expected %h", name, got, exp);
  end
endtask

task automatic clear_expect();
  e_push  = 1'b0;
  e_pop   = 1'b0;
  e_alu   = 1'b0;
  e_rtn   = 1'b0;
  e_xm    = 1'b0;
  e_setc  = 1'b0;
  e_cval  = 1'b0;
  e_mode  = 1'b0;
  e_dec   = 1'b0;
  e_op    = saturn_alu_pkg::ALU_OP_ZERO;
  e_dest  = saturn_alu_pkg::ALU_REG_A;
  e_src1  = saturn_alu_pkg::ALU_REG_A;
  e_src2  = saturn_alu_pkg::ALU_REG_A;
  e_field = saturn_field_pkg::FIELD_NONE;
  e_start = 4'd0;
  e_last  = 4'd0;
endtask

task automatic set_alu(input saturn_alu_pkg::alu_op_e op, input saturn_alu_pkg::alu_reg_e dest,
                       input saturn_alu_pkg::alu_reg_e src1);
  e_alu  = 1'b1;
  e_op   = op;
  e_dest = dest;
  e_src1 = src1;
endtask

task automatic set_field(input saturn_field_pkg::field_e code, input logic [3:0] first,
                         input logic [3:0] last);
  e_field = code;
  e_start = first;
  e_last  = last;
endtask

task automatic check_outputs();
  check_val("o_push", o_push, e_push);
  check_val("o_pop", o_pop, e_pop);
  check_val("o_ins_alu_op", o_ins_alu_op, e_alu);
  check_val("o_alu_op", o_alu_op, e_op);
  check_val("o_reg_dest", o_reg_dest, e_dest);
  check_val("o_reg_src1", o_reg_src1, e_src1);
  check_val("o_reg_src2", o_reg_src2, e_src2);
  check_val("o_ins_rtn", o_ins_rtn, e_rtn);
  check_val("o_set_xm", o_set_xm, e_xm);
  check_val("o_set_carry", o_set_carry, e_setc);
  check_val("o_carry_val", o_carry_val, e_cval);
  check_val("o_ins_set_mode", o_ins_set_mode, e_mode);
  check_val("o_mode_dec", o_mode_dec, e_dec);
  check_val("o_field", o_field, e_field);
  check_val("o_field_start", o_field_start, e_start);
  check_val("o_field_last", o_field_last, e_last);
endtask

// idle cycles first, stalled or with the enable low, then one accepted nibble
task automatic send_nibble(input logic [3:0] nib, input logic [`SATURN_ADDR_W-1:0] pc);
  int gap;
  gap = (max_gap == 0) ? 0 : int'($urandom_range(max_gap));
  repeat (gap) begin
    i_stalled = 1'($urandom_range(1));
    i_en_dec  = i_stalled & 1'($urandom_range(1));
    i_pc      = `SATURN_ADDR_W'($urandom);
    i_nibble  = 4'($urandom);
    @(negedge i_clk);
  end
  i_en_dec  = 1'b1;
  i_stalled = 1'b0;
  i_pc      = pc;
  i_nibble  = nib;
  @(negedge i_clk);
  i_en_dec  = 1'b0;
  i_pc      = `SATURN_ADDR_W'($urandom);
endtask

// nibbles go out from the top of code at consecutive addresses, then the pulse is checked
task automatic run_instr(input logic [15:0] code, input int len, input logic bad);
  logic [`SATURN_ADDR_W-1:0] pc;
  int                        wait_cnt;
  pc = `SATURN_ADDR_W'($urandom);
  for (int k = 0; k < len; k++) begin
    send_nibble(code[15-4*k -: 4], pc + `SATURN_ADDR_W'(k));
  end
  wait_cnt = 0;
  while (!(o_ins_decoded || o_dec_error) && wait_cnt < 4) begin
    @(negedge i_clk);
    wait_cnt++;
  end
  checks++;
  assert (o_ins_decoded || o_dec_error) else begin
    errors++;
    $display("instruction %h gave neither a decoded nor an error pulse", code);
  end
  check_val("o_dec_error", o_dec_error, bad);
  check_val("o_ins_decoded", o_ins_decoded, !bad);
  if (!bad) begin
    check_val("o_ins_addr", o_ins_addr, pc);
    check_outputs();
  end
  // both pulses last a single cycle
  @(negedge i_clk);
  check_val("o_ins_decoded", o_ins_decoded, 1'b0);
  check_val("o_dec_error", o_dec_error, 1'b0);
endtask

task automatic test_reset_values();
  clear_expect();
  check_outputs();
  check_val("o_ins_decoded", o_ins_decoded, 1'b0);
  check_val("o_dec_error", o_dec_error, 1'b0);
endtask

// 00-03 returns, 04-05 hex and decimal mode
task automatic test_return_mode();
  for (int n = 0; n < 6; n++) begin
    clear_expect();
    if (n < 4) begin
      e_rtn  = 1'b1;
      e_xm   = (n == 0);
      e_setc = (n >= 2);
      e_cval = (n == 2);
    end else begin
      e_mode = 1'b1;
      e_dec  = (n == 5);
    end
    run_instr({4'h0, 4'(n), 8'h00}, 2, 1'b0);
  end
endtask

// 06-0D register moves, status ops and P increment or decrement
task automatic test_alu_ops();
  for (int n = 6; n < 14; n++) begin
    clear_expect();
    case (n)
      6: set_alu(saturn_alu_pkg::ALU_OP_COPY, saturn_alu_pkg::ALU_REG_RSTK,
                 saturn_alu_pkg::ALU_REG_C);
      7: set_alu(saturn_alu_pkg::ALU_OP_COPY, saturn_alu_pkg::ALU_REG_C,
                 saturn_alu_pkg::ALU_REG_RSTK);
      8: set_alu(saturn_alu_pkg::ALU_OP_ZERO, saturn_alu_pkg::ALU_REG_ST,
                 saturn_alu_pkg::ALU_REG_A);
      9: set_alu(saturn_alu_pkg::ALU_OP_COPY, saturn_alu_pkg::ALU_REG_C,
                 saturn_alu_pkg::ALU_REG_ST);
      10: set_alu(saturn_alu_pkg::ALU_OP_COPY, saturn_alu_pkg::ALU_REG_ST,
                  saturn_alu_pkg::ALU_REG_C);
      11: set_alu(saturn_alu_pkg::ALU_OP_EXCH, saturn_alu_pkg::ALU_REG_C,
                  saturn_alu_pkg::ALU_REG_ST);
      12: set_alu(saturn_alu_pkg::ALU_OP_INC, saturn_alu_pkg::ALU_REG_A,
                  saturn_alu_pkg::ALU_REG_A);
      default: set_alu(saturn_alu_pkg::ALU_OP_DEC, saturn_alu_pkg::ALU_REG_A,
                       saturn_alu_pkg::ALU_REG_A);
    endcase
    e_push = (n == 6);
    e_pop  = (n == 7);
    // 5 digits for the return stack, 4 for ST
    e_last = (n < 8) ? 4'd4 : ((n < 12) ? 4'd3 : 4'd0);
    run_instr({4'h0, 4'(n), 8'h00}, 2, 1'b0);
  end
endtask

// 0Efx for table f entries and both AND/OR and register pair choices
task automatic test_logic_group();
  logic [3:0] p;
  logic [3:0] x;
  for (int f = 0; f < 16; f++) begin
    if (f >= 8 && f < 15) continue;
    for (int xi = 0; xi < 4; xi++) begin
      p = 4'($urandom);
      x = {xi[1], 2'b00, xi[0]};
      clear_expect();
      case (f)
        0: set_field(saturn_field_pkg::FIELD_P, p, p);
        1: set_field(saturn_field_pkg::FIELD_WP, 4'd0, p);
        2: set_field(saturn_field_pkg::FIELD_XS, 4'd2, 4'd2);
        3: set_field(saturn_field_pkg::FIELD_X, 4'd0, 4'd2);
        4: set_field(saturn_field_pkg::FIELD_S, 4'd15, 4'd15);
        5: set_field(saturn_field_pkg::FIELD_M, 4'd3, 4'd14);
        6: set_field(saturn_field_pkg::FIELD_B, 4'd0, 4'd1);
        7: set_field(saturn_field_pkg::FIELD_W, 4'd0, 4'd15);
        default: set_field(saturn_field_pkg::FIELD_A, 4'd0, 4'd4);
      endcase
      e_alu  = 1'b1;
      e_op   = x[3] ? saturn_alu_pkg::ALU_OP_OR : saturn_alu_pkg::ALU_OP_AND;
      e_dest = x[0] ? saturn_alu_pkg::ALU_REG_C : saturn_alu_pkg::ALU_REG_A;
      e_src1 = e_dest;
      e_src2 = x[0] ? saturn_alu_pkg::ALU_REG_A : saturn_alu_pkg::ALU_REG_C;
      i_reg_p = p;
      run_instr({8'h0E, 4'(f), x}, 4, 1'b0);
    end
  end
endtask

// illegal instruction followed by SETDEC, which must decode normally
task automatic bad_then_good(input logic [15:0] code, input int len);
  run_instr(code, len, 1'b1);
  clear_expect();
  e_mode = 1'b1;
  e_dec  = 1'b1;
  run_instr(16'h0500, 2, 1'b0);
endtask

task automatic test_illegal();
  for (int n = 1; n < 16; n++) begin
    bad_then_good({4'(n), 12'h000}, 1);
  end
  bad_then_good(16'h0F00, 2);
  for (int f = 8; f < 15; f++) begin
    bad_then_good({8'h0E, 4'(f), 4'h0}, 3);
  end
  for (int x = 0; x < 16; x++) begin
    if (x[2:1] != 2'b00) begin
      bad_then_good({12'h0E7, 4'(x)}, 4);
    end
  end
endtask

//--- testbench/saturn_decoder_tb.sv
// testbench top for the nibble-serial decoder with clock, reset, watchdog and result line
`default_nettype none
`timescale 1ns/10ps

`include "saturn_dec_cfg.svh"

module saturn_decoder_tb;

  localparam int PERIOD_NS   = 4;
  localparam int NUM_INSTR   = 256;
  localparam int MAX_NIBBLES = 4;
  localparam int MAX_STALL   = 3;
  // each nibble costs its stall cycles, the accepting cycle and a pulse cycle
  localparam int WATCHDOG_NS = NUM_INSTR * MAX_NIBBLES * (MAX_STALL + 2) * PERIOD_NS
                               + 2000;

  logic                        i_clk = 1'b0;
  logic                        i_reset;
  logic                        i_en_dec;
  logic                        i_stalled;
  logic [`SATURN_ADDR_W-1:0]   i_pc;
  logic [`SATURN_NIBBLE_W-1:0] i_nibble;
  logic [`SATURN_NIBBLE_W-1:0] i_reg_p;
  logic [`SATURN_ADDR_W-1:0]   o_ins_addr;
  logic                        o_ins_decoded;
  logic                        o_dec_error;
  logic                        o_push;
  logic                        o_pop;
  logic                        o_ins_alu_op;
  saturn_alu_pkg::alu_op_e     o_alu_op;
  saturn_alu_pkg::alu_reg_e    o_reg_dest;
  saturn_alu_pkg::alu_reg_e    o_reg_src1;
  saturn_alu_pkg::alu_reg_e    o_reg_src2;
  logic                        o_ins_rtn;
  logic                        o_set_xm;
  logic                        o_set_carry;
  logic                        o_carry_val;
  logic                        o_ins_set_mode;
  logic                        o_mode_dec;
  saturn_field_pkg::field_e    o_field;
  logic [`SATURN_NIBBLE_W-1:0] o_field_start;
  logic [`SATURN_NIBBLE_W-1:0] o_field_last;

  // expected decode results of the current instruction
  logic       e_push;
  logic       e_pop;
  logic       e_alu;
  logic       e_rtn;
  logic       e_xm;
  logic       e_setc;
  logic       e_cval;
  logic       e_mode;
  logic       e_dec;
  logic [4:0] e_op;
  logic [4:0] e_dest;
  logic [4:0] e_src1;
  logic [4:0] e_src2;
  logic [3:0] e_field;
  logic [3:0] e_start;
  logic [3:0] e_last;

  int errors  = 0;
  int checks  = 0;
  int max_gap = 0;

  saturn_decoder dut_i (.*);

  initial begin
    forever #(PERIOD_NS / 2) i_clk = ~i_clk;
  end

  `include "saturn_decoder_tests.svh"

  initial begin
    void'($urandom(32'hdf695d99));
    i_reset   = 1'b1;
    i_en_dec  = 1'b0;
    i_stalled = 1'b0;
    i_pc      = '0;
    i_nibble  = '0;
    i_reg_p   = '0;
    repeat (4) @(negedge i_clk);
    i_reset = 1'b0;
    test_reset_values();
    // second pass repeats everything with random idle cycles
    for (int pass = 0; pass < 2; pass++) begin
      max_gap = pass * MAX_STALL;
      test_return_mode();
      test_alu_ops();
      test_logic_group();
      test_illegal();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all instructions were decoded");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
+incdir+testbench
hdl/saturn_alu_pkg.sv
hdl/saturn_field_pkg.sv
hdl/saturn_dec_step_if.sv
hdl/saturn_nibble_sequencer.sv
hdl/saturn_group0_decoder.sv
hdl/saturn_field_decoder.sv
hdl/saturn_decoder.sv
testbench/saturn_decoder_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decoder testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module saturn_decoder_tb \
  -o saturn_decoder_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/saturn_decoder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" sim.log; then
  exit 0
fi
exit 1
